// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - lsu_pkg.sv
      - lsu_req_capture.sv
      - lsu_bus_master.sv
      - lsu_load_align.sv
      - lsu_top.sv
  - target: test
    files:
      - lsu_checker.sv
      - lsu_assertions.sv
      - tb_lsu.sv

// File: list.f
lsu_pkg.sv
lsu_req_capture.sv
lsu_bus_master.sv
lsu_load_align.sv
lsu_top.sv
lsu_checker.sv
lsu_assertions.sv
tb_lsu.sv

// File: lsu_assertions.sv
// bound into lsu_bus_master; fail_count is read by the testbench
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
	input wire            clock,
	input wire            rstn,
	input wire            ar_valid_i,
	input wire            ar_ready_i,
	input lsu_pkg::addr_t ar_addr_i,
	input wire            aw_valid_i,
	input wire            aw_ready_i,
	input lsu_pkg::addr_t aw_addr_i,
	input wire            w_valid_i,
	input wire            w_ready_i,
	input lsu_pkg::word_t w_data_i,
	input lsu_pkg::strb_t w_strb_i,
	input wire            done_i
);

	int fail_count = 0;

	// valids stay up with a steady payload until the transfer
	ar_hold: assert property (@(posedge clock) disable iff (!rstn)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
	else begin
		fail_count++;
		$error("read address dropped or moved before transfer");
	end
	aw_hold: assert property (@(posedge clock) disable iff (!rstn)
		aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i))
	else begin
		fail_count++;
		$error("write address dropped or moved before transfer");
	end
	w_hold: assert property (@(posedge clock) disable iff (!rstn)
		w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i) && $stable(w_strb_i))
	else begin
		fail_count++;
		$error("write data dropped or moved before transfer");
	end

	// never a read and a write at once
	one_dir: assert property (@(posedge clock) disable iff (!rstn) !(ar_valid_i && aw_valid_i))
	else begin
		fail_count++;
		$error("read and write address valid together");
	end

	// done is a single cycle
	done_pulse: assert property (@(posedge clock) disable iff (!rstn) done_i |=> !done_i)
	else begin
		fail_count++;
		$error("done held longer than one cycle");
	end

endmodule

bind lsu_bus_master lsu_assertions u_assertions (
	.clock      (clock),
	.rstn       (rstn),
	.ar_valid_i (ar_valid_o),
	.ar_ready_i (ar_ready_i),
	.ar_addr_i  (ar_addr_o),
	.aw_valid_i (aw_valid_o),
	.aw_ready_i (aw_ready_i),
	.aw_addr_i  (aw_addr_o),
	.w_valid_i  (w_valid_o),
	.w_ready_i  (w_ready_i),
	.w_data_i   (w_data_o),
	.w_strb_i   (w_strb_o),
	.done_i     (done_o)
);

`default_nettype wire

// File: lsu_bus_master.sv
// one transaction at a time; no timeout, waits on the slave forever; word-crossing accesses unsupported
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_master (
	input  wire                     clock,
	input  wire                     rstn,
	input  lsu_pkg::lsu_req_t       req_i,
	input  wire                     req_valid_i,
	// read address
	output lsu_pkg::addr_t          ar_addr_o,
	output lsu_pkg::bus_size_t      ar_size_o,
	output logic                    ar_valid_o,
	input  wire                     ar_ready_i,
	// read data
	input  lsu_pkg::word_t          r_data_i,
	input  lsu_pkg::bus_resp_t      r_resp_i,
	input  wire                     r_valid_i,
	output logic                    r_ready_o,
	// write address
	output lsu_pkg::addr_t          aw_addr_o,
	output lsu_pkg::bus_size_t      aw_size_o,
	output logic                    aw_valid_o,
	input  wire                     aw_ready_i,
	// write data
	output lsu_pkg::word_t          w_data_o,
	output lsu_pkg::strb_t          w_strb_o,
	output logic                    w_valid_o,
	input  wire                     w_ready_i,
	// write response
	input  lsu_pkg::bus_resp_t      b_resp_i,
	input  wire                     b_valid_i,
	output logic                    b_ready_o,
	// status toward the other blocks
	output logic                    busy_o,
	output logic                    done_o,
	output lsu_pkg::lsu_resp_t      resp_o
);

	lsu_pkg::lsu_state_e state_q;
	lsu_pkg::lsu_state_e state_d;
	logic                aw_sent_q;
	logic                w_sent_q;
	logic                ar_fire;
	logic                aw_fire;
	logic                w_fire;
	logic                r_fire;
	logic                b_fire;
	logic                store_addr_ok;
	lsu_pkg::strb_t      strb_base;
	logic [4:0]          lane_shift;

	// handshakes
	assign ar_fire = ar_valid_o & ar_ready_i;
	assign aw_fire = aw_valid_o & aw_ready_i;
	assign w_fire  = w_valid_o & w_ready_i;
	assign r_fire  = r_valid_i & r_ready_o;
	assign b_fire  = b_valid_i & b_ready_o;

	// aw and w may finish in either order
	assign store_addr_ok = (aw_sent_q | aw_fire) & (w_sent_q | w_fire);

	// valids only in ST_ADDR; aw and w drop on their own transfer
	assign ar_valid_o = (state_q == lsu_pkg::ST_ADDR) & req_i.is_load;
	assign aw_valid_o = (state_q == lsu_pkg::ST_ADDR) & req_i.is_store & ~aw_sent_q;
	assign w_valid_o  = (state_q == lsu_pkg::ST_ADDR) & req_i.is_store & ~w_sent_q;
	assign r_ready_o  = (state_q == lsu_pkg::ST_RESP) & req_i.is_load;
	assign b_ready_o  = (state_q == lsu_pkg::ST_RESP) & req_i.is_store;

	assign busy_o = (state_q != lsu_pkg::ST_IDLE);
	assign done_o = (state_q == lsu_pkg::ST_DONE);

	// address straight from the alu result
	assign ar_addr_o = req_i.addr;
	assign aw_addr_o = req_i.addr;

	// size fields and unshifted strobe per kind
	always_comb begin
		case (req_i.load_kind)
			lsu_pkg::LOAD_LB, lsu_pkg::LOAD_LBU: ar_size_o = lsu_pkg::SIZE_1;
			lsu_pkg::LOAD_LH, lsu_pkg::LOAD_LHU: ar_size_o = lsu_pkg::SIZE_2;
			default:                             ar_size_o = lsu_pkg::SIZE_4;
		endcase
		case (req_i.store_kind)
			lsu_pkg::STORE_SB: begin
				aw_size_o = lsu_pkg::SIZE_1;
				strb_base = 4'b0001;
			end
			lsu_pkg::STORE_SH: begin
				aw_size_o = lsu_pkg::SIZE_2;
				strb_base = 4'b0011;
			end
			lsu_pkg::STORE_SW: begin
				aw_size_o = lsu_pkg::SIZE_4;
				strb_base = 4'b1111;
			end
			default: begin
				aw_size_o = lsu_pkg::SIZE_4;
				strb_base = 4'b0000;
			end
		endcase
	end

	// move strobe and data up to the addressed byte lanes
	assign lane_shift = {req_i.addr[1:0], 3'b000};
	assign w_strb_o   = lsu_pkg::strb_t'(strb_base << req_i.addr[1:0]);
	assign w_data_o   = req_i.store_data << lane_shift;

	// next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			lsu_pkg::ST_IDLE: begin
				if (req_valid_i) begin
					state_d = lsu_pkg::ST_ADDR;
				end
			end
			lsu_pkg::ST_ADDR: begin
				// non-memory skips the bus entirely
				if (!req_i.is_load && !req_i.is_store) begin
					state_d = lsu_pkg::ST_DONE;
				end else if (req_i.is_load && ar_fire) begin
					state_d = lsu_pkg::ST_RESP;
				end else if (req_i.is_store && store_addr_ok) begin
					state_d = lsu_pkg::ST_RESP;
				end
			end
			lsu_pkg::ST_RESP: begin
				if (r_fire || b_fire) begin
					state_d = lsu_pkg::ST_DONE;
				end
			end
			default: begin
				// ST_DONE lasts one cycle
				state_d = lsu_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= lsu_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// sent flags, cleared whenever we are outside ST_ADDR
	always_ff @(posedge clock) begin
		if (!rstn || state_q != lsu_pkg::ST_ADDR) begin
			aw_sent_q <= 1'b0;
			w_sent_q  <= 1'b0;
		end else begin
			aw_sent_q <= aw_sent_q | aw_fire;
			w_sent_q  <= w_sent_q | w_fire;
		end
	end

	// read word capture, payload only
	always_ff @(posedge clock) begin
		if (r_fire) begin
			resp_o.rdata <= r_data_i;
		end
	end

	// error bit, fresh for each request
	always_ff @(posedge clock) begin
		if (!rstn || req_valid_i) begin
			resp_o.err <= 1'b0;
		end else if (r_fire) begin
			resp_o.err <= (r_resp_i != lsu_pkg::RESP_OKAY);
		end else if (b_fire) begin
			resp_o.err <= (b_resp_i != lsu_pkg::RESP_OKAY);
		end
	end

endmodule

`default_nettype wire

// File: lsu_checker.sv
// samples on the rising edge where transfers happen; expected values come from the testbench row
`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
	input  wire                  clock,
	input  wire                  rstn,
	input  wire [135:0]          row_i,
	input  lsu_pkg::addr_t       ar_addr_i,
	input  lsu_pkg::bus_size_t   ar_size_i,
	input  wire                  ar_valid_i,
	input  wire                  ar_ready_i,
	input  lsu_pkg::addr_t       aw_addr_i,
	input  lsu_pkg::bus_size_t   aw_size_i,
	input  wire                  aw_valid_i,
	input  wire                  aw_ready_i,
	input  lsu_pkg::word_t       w_data_i,
	input  lsu_pkg::strb_t       w_strb_i,
	input  wire                  w_valid_i,
	input  wire                  w_ready_i,
	input  wire                  r_ready_i,
	input  wire                  b_ready_i,
	input  lsu_pkg::lsu_wb_t     wb_i,
	input  wire                  wb_valid_i,
	output int                   err_count_o,
	output int                   wb_count_o
);

	typedef struct packed {
		logic [7:0]  num;
		logic [3:0]  load_kind;
		logic [3:0]  store_kind;
		logic [31:0] addr;
		logic [31:0] sdata;
		logic [7:0]  wreg;
		logic [3:0]  wd;
		logic [3:0]  inject;
		logic [31:0] exp_val;
		logic [3:0]  exp_strb;
		logic [3:0]  exp_err;
	} test_row_t;

	test_row_t   row;
	int          test_errs = 0;
	logic        ar_seen = 1'b0;
	logic        aw_seen = 1'b0;
	logic        w_seen = 1'b0;
	logic        is_load;
	logic        is_store;
	logic        exp_wen;
	logic [31:0] exp_data;

	assign row      = row_i;
	assign is_load  = (row.load_kind != 4'd0);
	assign is_store = (row.store_kind != 4'd0);

	initial begin
		err_count_o = 0;
		wb_count_o  = 0;
	end

	// size field is log2 of 1, 2 or 4 bytes
	function automatic logic [2:0] log2_bytes(input logic [3:0] kind, input logic store);
		logic [2:0] sz;
		sz = 3'd2;
		if (store) begin
			if (kind == 4'd1) sz = 3'd0;
			if (kind == 4'd2) sz = 3'd1;
		end else begin
			if (kind == 4'd1 || kind == 4'd4) sz = 3'd0;
			if (kind == 4'd2 || kind == 4'd5) sz = 3'd1;
		end
		return sz;
	endfunction

	task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
		$display("ERR %0t: test %0d %s got %h expected %h", $time, row.num, what, got, exp);
		test_errs++;
		err_count_o++;
	endtask

	// anything wrong that is not a value mismatch
	task automatic report_failure(input string what);
		$display("test %0d: %s", row.num, what);
		test_errs++;
		err_count_o++;
	endtask

	always @(posedge clock) begin
		if (rstn) begin
			// read address transfer
			if (ar_valid_i && ar_ready_i) begin
				if (!is_load) begin
					report_failure("read address sent for an instruction that is no load");
				end
				ar_seen = 1'b1;
				if (ar_addr_i !== row.addr) mismatch("read address", ar_addr_i, row.addr);
				if (ar_size_i !== log2_bytes(row.load_kind, 1'b0))
					mismatch("read size", ar_size_i, log2_bytes(row.load_kind, 1'b0));
			end
			// write address transfer
			if (aw_valid_i && aw_ready_i) begin
				if (!is_store) begin
					report_failure("write address sent for an instruction that is no store");
				end
				aw_seen = 1'b1;
				if (aw_addr_i !== row.addr) mismatch("write address", aw_addr_i, row.addr);
				if (aw_size_i !== log2_bytes(row.store_kind, 1'b1))
					mismatch("write size", aw_size_i, log2_bytes(row.store_kind, 1'b1));
			end
			// write data lanes and strobe
			if (w_valid_i && w_ready_i) begin
				if (!is_store) begin
					report_failure("write data sent for an instruction that is no store");
				end
				w_seen = 1'b1;
				if (w_data_i !== row.exp_val) mismatch("write data", w_data_i, row.exp_val);
				if (w_strb_i !== row.exp_strb) mismatch("write strobe", w_strb_i, row.exp_strb);
			end
			// response readies open only once the request is out on the bus
			if (r_ready_i && !ar_seen) begin
				report_failure("read data ready raised before a read address transfer");
			end
			if (b_ready_i && !(aw_seen && w_seen)) begin
				report_failure("write response ready raised before address and data transfers");
			end
			// writeback closes the test
			if (wb_valid_i) begin
				wb_count_o++;
				exp_wen  = row.wd[0] && !is_store;
				exp_data = is_store ? row.addr : row.exp_val;
				if (wb_i.wen !== exp_wen) mismatch("write enable", wb_i.wen, exp_wen);
				if (wb_i.wreg !== row.wreg[4:0])
					mismatch("register index", wb_i.wreg, row.wreg[4:0]);
				if (wb_i.wdata !== exp_data) mismatch("write value", wb_i.wdata, exp_data);
				if (wb_i.err !== row.exp_err[0]) mismatch("error bit", wb_i.err, row.exp_err[0]);
				if (is_load && !ar_seen) begin
					report_failure("load finished without a read address transfer");
				end
				if (is_store && !(aw_seen && w_seen)) begin
					report_failure("store finished without its write address and data transfers");
				end
				if (test_errs == 0) begin
					$display("test %0d: ok", row.num);
				end else begin
					$display("test %0d: %0d failed checks", row.num, test_errs);
				end
				test_errs = 0;
				ar_seen   = 1'b0;
				aw_seen   = 1'b0;
				w_seen    = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: lsu_load_align.sv
// assumes loads stay inside one word; req_i and resp_i must be stable while done_i is high
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
	input  wire                     clock,
	input  wire                     rstn,
	input  lsu_pkg::lsu_req_t       req_i,
	input  lsu_pkg::lsu_resp_t      resp_i,
	input  wire                     done_i,
	output lsu_pkg::lsu_wb_t        wb_o,
	output logic                    wb_valid_o
);

	logic [4:0]       lane_shift;
	lsu_pkg::word_t   shifted;
	lsu_pkg::word_t   load_val;
	lsu_pkg::lsu_wb_t wb_d;

	// bring the addressed lane down to bit 0
	assign lane_shift = {req_i.addr[1:0], 3'b000};
	assign shifted    = resp_i.rdata >> lane_shift;

	// sign or zero extend by kind
	always_comb begin
		case (req_i.load_kind)
			lsu_pkg::LOAD_LB:  load_val = {{24{shifted[7]}}, shifted[7:0]};
			lsu_pkg::LOAD_LH:  load_val = {{16{shifted[15]}}, shifted[15:0]};
			lsu_pkg::LOAD_LBU: load_val = {24'b0, shifted[7:0]};
			lsu_pkg::LOAD_LHU: load_val = {16'b0, shifted[15:0]};
			default:           load_val = shifted;
		endcase
	end

	// stores never write the register file
	assign wb_d.wen   = req_i.wd & ~req_i.is_store;
	assign wb_d.wreg  = req_i.wreg;
	// alu result for everything but loads
	assign wb_d.wdata = req_i.is_load ? load_val : req_i.addr;
	assign wb_d.err   = resp_i.err;

	// record only moves on done
	always_ff @(posedge clock) begin
		if (done_i) begin
			wb_o <= wb_d;
		end
	end

	// writeback pulse, one cycle behind done
	always_ff @(posedge clock) begin
		if (!rstn) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= done_i;
		end
	end

endmodule

`default_nettype wire

// File: lsu_patterns.txt
// num load store addr sdata reg wd inject exp_val exp_strb exp_err (hex)
// load 1=LB 2=LH 3=LW 4=LBU 5=LHU, store 1=SB 2=SH 3=SW; exp_val is w_data for stores
01_0_0_12345678_00000000_05_1_0_12345678_0_0
02_0_0_deadbeef_00000000_0a_0_0_deadbeef_0_0
03_0_3_00000020_8badf00d_01_1_0_8badf00d_f_0
04_0_1_00000040_000000a5_03_1_0_000000a5_1_0
05_0_1_00000041_11223381_04_1_0_22338100_2_0
06_0_1_00000042_0000007f_04_1_0_007f0000_4_0
07_0_1_00000043_000000c3_04_1_0_c3000000_8_0
08_0_2_00000050_0000beef_05_1_0_0000beef_3_0
09_0_2_00000052_00008001_05_1_0_80010000_c_0
0a_1_0_00000041_00000000_06_1_0_ffffff81_0_0
0b_4_0_00000041_00000000_07_1_0_00000081_0_0
0c_1_0_00000042_00000000_08_1_0_0000007f_0_0
0d_1_0_00000043_00000000_09_1_0_ffffffc3_0_0
0e_2_0_00000052_00000000_0b_1_0_ffff8001_0_0
0f_5_0_00000052_00000000_0c_1_0_00008001_0_0
10_2_0_00000050_00000000_0d_1_0_ffffbeef_0_0
11_3_0_00000020_00000000_0e_1_0_8badf00d_0_0
12_3_0_00000040_00000000_0f_1_0_c37f81a5_0_0
13_3_0_00000050_00000000_10_1_1_8001beef_0_1
14_0_3_00000060_cafef00d_11_1_1_cafef00d_f_1

// File: lsu_pkg.sv
// widths are tied to the 32-bit word and 4-bit strobe; kind codes must match the execute stage encoding
`default_nettype none

package lsu_pkg;

	// widths with a meaning
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  strb_t;

	// load kind as decoded by execute
	typedef logic [2:0] load_kind_t;
	localparam load_kind_t LOAD_NONE = 3'd0;
	localparam load_kind_t LOAD_LB   = 3'd1;
	localparam load_kind_t LOAD_LH   = 3'd2;
	localparam load_kind_t LOAD_LW   = 3'd3;
	localparam load_kind_t LOAD_LBU  = 3'd4;
	localparam load_kind_t LOAD_LHU  = 3'd5;

	// store kind, zero means no store
	typedef logic [1:0] store_kind_t;
	localparam store_kind_t STORE_NONE = 2'd0;
	localparam store_kind_t STORE_SB   = 2'd1;
	localparam store_kind_t STORE_SH   = 2'd2;
	localparam store_kind_t STORE_SW   = 2'd3;

	// bus size field holds log2 of the byte count
	typedef logic [2:0] bus_size_t;
	localparam bus_size_t SIZE_1 = 3'd0;
	localparam bus_size_t SIZE_2 = 3'd1;
	localparam bus_size_t SIZE_4 = 3'd2;

	// bus response, anything nonzero is an error
	typedef logic [1:0] bus_resp_t;
	localparam bus_resp_t RESP_OKAY = 2'b00;

	// bus state machine
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_RESP,
		ST_DONE
	} lsu_state_e;

	// one instruction's execute result
	typedef struct packed {
		logic        is_load;
		logic        is_store;
		load_kind_t  load_kind;
		store_kind_t store_kind;
		// alu result doubles as the address
		addr_t       addr;
		word_t       store_data;
		reg_idx_t    wreg;
		logic        wd;
	} lsu_req_t;

	// raw read word plus error
	typedef struct packed {
		word_t rdata;
		logic  err;
	} lsu_resp_t;

	// writeback record
	typedef struct packed {
		logic     wen;
		reg_idx_t wreg;
		word_t    wdata;
		logic     err;
	} lsu_wb_t;

endpackage

`default_nettype wire

// File: lsu_req_capture.sv
// starts are dropped while busy_i is high or a request is still being handed over
`timescale 1ns/1ps
`default_nettype none

module lsu_req_capture (
	input  wire                     clock,
	input  wire                     rstn,
	input  wire                     start_i,
	input  lsu_pkg::addr_t          alu_result_i,
	input  lsu_pkg::word_t          store_data_i,
	input  lsu_pkg::load_kind_t     load_kind_i,
	input  lsu_pkg::store_kind_t    store_kind_i,
	input  lsu_pkg::reg_idx_t       wreg_i,
	input  wire                     wd_i,
	input  wire                     busy_i,
	output lsu_pkg::lsu_req_t       req_o,
	output logic                    req_valid_o
);

	logic accept;

	// busy_i only rises a cycle after req_valid_o, so cover that gap too
	assign accept = start_i & ~busy_i & ~req_valid_o;

	// request record, held until the next accepted start
	always_ff @(posedge clock) begin
		if (accept) begin
			req_o.is_load    <= (load_kind_i != lsu_pkg::LOAD_NONE);
			req_o.is_store   <= (store_kind_i != lsu_pkg::STORE_NONE);
			req_o.load_kind  <= load_kind_i;
			req_o.store_kind <= store_kind_i;
			req_o.addr       <= alu_result_i;
			req_o.store_data <= store_data_i;
			req_o.wreg       <= wreg_i;
			req_o.wd         <= wd_i;
		end
	end

	// one-cycle handoff pulse
	always_ff @(posedge clock) begin
		if (!rstn) begin
			req_valid_o <= 1'b0;
		end else begin
			req_valid_o <= accept;
		end
	end

endmodule

`default_nettype wire

// File: lsu_top.sv
// one instruction in flight; start_i while busy is ignored; wb_valid_o ends each instruction
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
	input  wire                     clock,
	input  wire                     rstn,
	// execute stage
	input  wire                     start_i,
	input  lsu_pkg::addr_t          alu_result_i,
	input  lsu_pkg::word_t          store_data_i,
	input  lsu_pkg::load_kind_t     load_kind_i,
	input  lsu_pkg::store_kind_t    store_kind_i,
	input  lsu_pkg::reg_idx_t       wreg_i,
	input  wire                     wd_i,
	// data bus
	output lsu_pkg::addr_t          ar_addr_o,
	output lsu_pkg::bus_size_t      ar_size_o,
	output logic                    ar_valid_o,
	input  wire                     ar_ready_i,
	input  lsu_pkg::word_t          r_data_i,
	input  lsu_pkg::bus_resp_t      r_resp_i,
	input  wire                     r_valid_i,
	output logic                    r_ready_o,
	output lsu_pkg::addr_t          aw_addr_o,
	output lsu_pkg::bus_size_t      aw_size_o,
	output logic                    aw_valid_o,
	input  wire                     aw_ready_i,
	output lsu_pkg::word_t          w_data_o,
	output lsu_pkg::strb_t          w_strb_o,
	output logic                    w_valid_o,
	input  wire                     w_ready_i,
	input  lsu_pkg::bus_resp_t      b_resp_i,
	input  wire                     b_valid_i,
	output logic                    b_ready_o,
	// writeback
	output lsu_pkg::lsu_wb_t        wb_o,
	output logic                    wb_valid_o
);

	lsu_pkg::lsu_req_t  req;
	lsu_pkg::lsu_resp_t resp;
	logic               req_valid;
	logic               busy;
	logic               done;

	lsu_req_capture u_req_capture (
		.clock        (clock),
		.rstn         (rstn),
		.start_i      (start_i),
		.alu_result_i (alu_result_i),
		.store_data_i (store_data_i),
		.load_kind_i  (load_kind_i),
		.store_kind_i (store_kind_i),
		.wreg_i       (wreg_i),
		.wd_i         (wd_i),
		.busy_i       (busy),
		.req_o        (req),
		.req_valid_o  (req_valid)
	);

	lsu_bus_master u_bus_master (
		.clock       (clock),
		.rstn        (rstn),
		.req_i       (req),
		.req_valid_i (req_valid),
		.ar_addr_o   (ar_addr_o),
		.ar_size_o   (ar_size_o),
		.ar_valid_o  (ar_valid_o),
		.ar_ready_i  (ar_ready_i),
		.r_data_i    (r_data_i),
		.r_resp_i    (r_resp_i),
		.r_valid_i   (r_valid_i),
		.r_ready_o   (r_ready_o),
		.aw_addr_o   (aw_addr_o),
		.aw_size_o   (aw_size_o),
		.aw_valid_o  (aw_valid_o),
		.aw_ready_i  (aw_ready_i),
		.w_data_o    (w_data_o),
		.w_strb_o    (w_strb_o),
		.w_valid_o   (w_valid_o),
		.w_ready_i   (w_ready_i),
		.b_resp_i    (b_resp_i),
		.b_valid_i   (b_valid_i),
		.b_ready_o   (b_ready_o),
		.busy_o      (busy),
		.done_o      (done),
		.resp_o      (resp)
	);

	lsu_load_align u_load_align (
		.clock      (clock),
		.rstn       (rstn),
		.req_i      (req),
		.resp_i     (resp),
		.done_i     (done),
		.wb_o       (wb_o),
		.wb_valid_o (wb_valid_o)
	);

endmodule

`default_nettype wire

// File: tb_lsu.sv
// reads lsu_patterns.txt from the project root; slave memory covers byte addresses 0x00 to 0xff only
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

	localparam int MAX_TESTS       = 64;
	localparam int CYCLES_PER_TEST = 40;

	// one pattern row, same column order as the file
	typedef struct packed {
		logic [7:0]  num;
		logic [3:0]  load_kind;
		logic [3:0]  store_kind;
		logic [31:0] addr;
		logic [31:0] sdata;
		logic [7:0]  wreg;
		logic [3:0]  wd;
		logic [3:0]  inject;
		logic [31:0] exp_val;
		logic [3:0]  exp_strb;
		logic [3:0]  exp_err;
	} test_row_t;

	logic                 clock = 1'b0;
	logic                 rstn;
	// execute side
	logic                 start_i;
	lsu_pkg::addr_t       alu_result_i;
	lsu_pkg::word_t       store_data_i;
	lsu_pkg::load_kind_t  load_kind_i;
	lsu_pkg::store_kind_t store_kind_i;
	lsu_pkg::reg_idx_t    wreg_i;
	logic                 wd_i;
	// bus, slave side starts idle
	lsu_pkg::addr_t       ar_addr_o;
	lsu_pkg::bus_size_t   ar_size_o;
	logic                 ar_valid_o;
	logic                 ar_ready_i = 1'b0;
	lsu_pkg::word_t       r_data_i = '0;
	lsu_pkg::bus_resp_t   r_resp_i = '0;
	logic                 r_valid_i = 1'b0;
	logic                 r_ready_o;
	lsu_pkg::addr_t       aw_addr_o;
	lsu_pkg::bus_size_t   aw_size_o;
	logic                 aw_valid_o;
	logic                 aw_ready_i = 1'b0;
	lsu_pkg::word_t       w_data_o;
	lsu_pkg::strb_t       w_strb_o;
	logic                 w_valid_o;
	logic                 w_ready_i = 1'b0;
	lsu_pkg::bus_resp_t   b_resp_i = '0;
	logic                 b_valid_i = 1'b0;
	logic                 b_ready_o;
	lsu_pkg::lsu_wb_t     wb_o;
	logic                 wb_valid_o;

	logic [135:0]         pat_mem [0:MAX_TESTS-1];
	test_row_t            row = '0;
	int                   n_tests = 0;
	int                   cycles = 0;
	int                   limit = CYCLES_PER_TEST;
	int                   err_count;
	int                   wb_count;
	int                   assert_fails;

	// slave model state
	integer               seed = 79;
	lsu_pkg::word_t       mem [0:63];
	lsu_pkg::addr_t       rd_addr;
	lsu_pkg::addr_t       wr_addr;
	lsu_pkg::word_t       wr_data;
	lsu_pkg::strb_t       wr_strb;
	logic                 r_pend;
	logic                 b_pend;
	logic                 aw_got;
	logic                 w_got;
	logic                 r_took = 1'b0;
	logic                 b_took = 1'b0;
	int                   ar_wait;
	int                   aw_wait;
	int                   w_wait;
	int                   r_wait;
	int                   b_wait;

	always #2 clock = ~clock;

	lsu_top u_dut (.*);

	lsu_checker u_chk (
		.clock       (clock),
		.rstn        (rstn),
		.row_i       (row),
		.ar_addr_i   (ar_addr_o),
		.ar_size_i   (ar_size_o),
		.ar_valid_i  (ar_valid_o),
		.ar_ready_i  (ar_ready_i),
		.aw_addr_i   (aw_addr_o),
		.aw_size_i   (aw_size_o),
		.aw_valid_i  (aw_valid_o),
		.aw_ready_i  (aw_ready_i),
		.w_data_i    (w_data_o),
		.w_strb_i    (w_strb_o),
		.w_valid_i   (w_valid_o),
		.w_ready_i   (w_ready_i),
		.r_ready_i   (r_ready_o),
		.b_ready_i   (b_ready_o),
		.wb_i        (wb_o),
		.wb_valid_i  (wb_valid_o),
		.err_count_o (err_count),
		.wb_count_o  (wb_count)
	);

	assign assert_fails = u_dut.u_bus_master.u_assertions.fail_count;

	// ready/valid delay of 0 to 3 cycles
	function automatic int pick_delay();
		return {$random(seed)} % 4;
	endfunction

	// one instruction, then starts during the handover and while busy that must be dropped
	task automatic run_test(input test_row_t t);
		@(negedge clock);
		row          = t;
		alu_result_i = t.addr;
		store_data_i = t.sdata;
		load_kind_i  = t.load_kind[2:0];
		store_kind_i = t.store_kind[1:0];
		wreg_i       = t.wreg[4:0];
		wd_i         = t.wd[0];
		start_i      = 1'b1;
		@(negedge clock);
		// garbage non-memory request, would show up as a wrong writeback
		alu_result_i = ~t.addr;
		wreg_i       = ~t.wreg[4:0];
		load_kind_i  = '0;
		store_kind_i = '0;
		// start stays up through the handover cycle and the first busy cycle
		repeat (2) @(negedge clock);
		start_i = 1'b0;
		while (!wb_valid_o) begin
			@(negedge clock);
		end
	endtask

	// read data and write response transfers, taken at the rising edge
	always @(posedge clock) begin
		r_took <= r_valid_i & r_ready_o;
		b_took <= b_valid_i & b_ready_o;
	end

	// bus slave, drives on the falling edge; a ready is only raised against a valid
	always @(negedge clock) begin
		if (!rstn) begin
			ar_ready_i = 1'b0;
			aw_ready_i = 1'b0;
			w_ready_i  = 1'b0;
			r_valid_i  = 1'b0;
			b_valid_i  = 1'b0;
			r_pend     = 1'b0;
			b_pend     = 1'b0;
			aw_got     = 1'b0;
			w_got      = 1'b0;
			ar_wait    = 0;
			aw_wait    = 0;
			w_wait     = 0;
			for (int i = 0; i < 64; i++) begin
				mem[i] = '0;
			end
		end else begin
			// read address
			if (ar_ready_i) begin
				ar_ready_i = 1'b0;
				r_pend     = 1'b1;
				r_wait     = pick_delay();
			end else if (ar_valid_o) begin
				if (ar_wait == 0) begin
					ar_ready_i = 1'b1;
					rd_addr    = ar_addr_o;
					ar_wait    = pick_delay();
				end else begin
					ar_wait--;
				end
			end
			// read data held until taken, error code when the row injects one
			if (r_valid_i) begin
				if (r_took) begin
					r_valid_i = 1'b0;
				end
			end else if (r_pend) begin
				if (r_wait == 0) begin
					r_valid_i = 1'b1;
					r_data_i  = mem[rd_addr[7:2]];
					r_resp_i  = row.inject[0] ? 2'b10 : 2'b00;
					r_pend    = 1'b0;
				end else begin
					r_wait--;
				end
			end
			// write address and write data run independently
			if (aw_ready_i) begin
				aw_ready_i = 1'b0;
				aw_got     = 1'b1;
			end else if (aw_valid_o) begin
				if (aw_wait == 0) begin
					aw_ready_i = 1'b1;
					wr_addr    = aw_addr_o;
					aw_wait    = pick_delay();
				end else begin
					aw_wait--;
				end
			end
			if (w_ready_i) begin
				w_ready_i = 1'b0;
				w_got     = 1'b1;
			end else if (w_valid_o) begin
				if (w_wait == 0) begin
					w_ready_i = 1'b1;
					wr_data   = w_data_o;
					wr_strb   = w_strb_o;
					w_wait    = pick_delay();
				end else begin
					w_wait--;
				end
			end
			// both halves in, commit strobed lanes
			if (aw_got && w_got) begin
				for (int i = 0; i < 4; i++) begin
					if (wr_strb[i]) begin
						mem[wr_addr[7:2]][8*i +: 8] = wr_data[8*i +: 8];
					end
				end
				aw_got = 1'b0;
				w_got  = 1'b0;
				b_pend = 1'b1;
				b_wait = pick_delay();
			end
			// write response, held until taken
			if (b_valid_i) begin
				if (b_took) begin
					b_valid_i = 1'b0;
				end
			end else if (b_pend) begin
				if (b_wait == 0) begin
					b_valid_i = 1'b1;
					b_resp_i  = row.inject[0] ? 2'b10 : 2'b00;
					b_pend    = 1'b0;
				end else begin
					b_wait--;
				end
			end
		end
	end

	// run limit scales with the row count
	always @(posedge clock) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		rstn         = 1'b0;
		start_i      = 1'b0;
		alu_result_i = '0;
		store_data_i = '0;
		load_kind_i  = '0;
		store_kind_i = '0;
		wreg_i       = '0;
		wd_i         = 1'b0;
		for (int i = 0; i < MAX_TESTS; i++) begin
			pat_mem[i] = '0;
		end
		$readmemh("lsu_patterns.txt", pat_mem);
		// test number zero ends the list
		while (n_tests < MAX_TESTS && pat_mem[n_tests][135:128] != 8'h00) begin
			n_tests++;
		end
		limit = (n_tests + 1) * CYCLES_PER_TEST;
		repeat (3) @(negedge clock);
		rstn = 1'b1;
		for (int i = 0; i < n_tests; i++) begin
			run_test(test_row_t'(pat_mem[i]));
		end
		// idle a while so a late extra writeback is still counted
		repeat (8) @(negedge clock);
		if (n_tests == 0) begin
			$display("no test rows could be read from lsu_patterns.txt");
		end
		if (wb_count != n_tests) begin
			$display("got %0d writebacks for %0d accepted starts", wb_count, n_tests);
		end
		$display("tests: %0d  writebacks: %0d  failed checks: %0d  assertion failures: %0d",
			n_tests, wb_count, err_count, assert_fails);
		if (n_tests != 0 && wb_count == n_tests && err_count == 0 && assert_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
